// ==== all.f ====
+incdir+verification
hdl/trace_pkg.sv
hdl/trace_recorder.sv
hdl/trace_fifo.sv
hdl/trace_port.sv
hdl/trace_unit.sv
verification/tb_trace_unit.sv

// ==== Makefile ====
# Verilator build and run of the trace unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
		--top-module tb_trace_unit -Mdir obj_dir -o sim_trace
	./obj_dir/sim_trace | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/trace_model.svh ====
// Reference model of the trace recorder
// Applies the record rules to one commit per cycle and queues the
// records that the readout port should hand out, in order
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

trace_pkg::trace_rec_t exp_q[$];   // Predicted records not yet read
logic                  m_tron;     // Trace flag
logic                  m_pend;     // Address record owed
int                    m_count;    // Branch bits held
int                    m_flush;    // Full flushes since the last address
logic [63:0]           m_hist;     // Branch bits, oldest at bit 0

function automatic void model_reset();
	exp_q.delete();
	m_tron  = 1'b0;
	m_pend  = 1'b0;
	m_count = 0;
	m_flush = 0;
	m_hist  = '0;
endfunction

// Buffer and port register together hold rec_cap records
function automatic void push_expected(input logic [1:0] kind, input int cnt,
		input trace_pkg::trace_word_t w);
	trace_pkg::trace_rec_t r;
	r       = '0;
	r.valid = 1'b1;
	r.kind  = kind;
	r.count = cnt[trace_pkg::cnt_w-1:0];
	r.word  = w;
	if (exp_q.size() < rec_cap)
		exp_q.push_back(r);
endfunction

function automatic void flush_history();
	trace_pkg::trace_word_t w;
	w = m_hist << trace_pkg::hist_base;
	w[trace_pkg::hist_base-1:2] = m_count[trace_pkg::cnt_w-1:0];
	w[1:0] = trace_pkg::kind_hist;
	push_expected(trace_pkg::kind_hist, m_count, w);
	m_count = 0;
	m_hist  = '0;
endfunction

function automatic void predict_commit(input trace_pkg::commit_t c,
		input trace_pkg::dbg_cfg_t d);
	logic                   hit;
	trace_pkg::trace_word_t w;
	hit = 1'b0;
	for (int i = 0; i < trace_pkg::n_match; i++) begin
		if (d.slot_en[i] && d.match_addr[i] == c.ip)
			hit = c.valid;
	end
	// Recording sees the flag as it stood before this commit
	if (m_tron && c.valid) begin
		if (!d.compress || m_pend) begin
			w      = c.ip;
			w[1:0] = trace_pkg::kind_addr;
			push_expected(trace_pkg::kind_addr, 0, w);
			m_pend = 1'b0;
		end else if (c.branch) begin
			m_hist[m_count[5:0]] = c.taken;   // Kept even when it fills the word
			m_count++;
			if (m_count == trace_pkg::hist_max) begin
				flush_history();
				m_flush++;
				if (m_flush == trace_pkg::flushes_per_addr) begin
					m_pend  = 1'b1;
					m_flush = 0;
				end
			end
		end else if (c.jump) begin
			flush_history();   // Partial word, count may be zero
			m_pend  = 1'b1;
			m_flush = 0;
		end
	end
	if (hit && !m_tron) begin
		m_tron = 1'b1;
		m_pend = 1'b1;
	end
endfunction

`endif

// ==== verification/tb_trace_unit.sv ====
// Testbench for the instruction trace unit
// Drives retired instruction streams and debug setups into the DUT,
// predicts the record stream with a reference model and compares each
// record handed out at the readout port
`timescale 1ns/1ns
`default_nettype none

module tb_trace_unit;

	localparam int fifo_depth_log2 = 4;
	localparam int rec_cap    = 2 ** fifo_depth_log2 + 1;   // FIFO entries plus port register
	localparam int clk_period = 40;
	localparam int drive_dly  = 5;
	localparam int wait_limit = 200;
	localparam logic [63:0] trig_addr = 64'h0000_0040_0000_0100;

	logic                  clk_g;
	logic                  rst_i;
	trace_pkg::commit_t    commit_i;
	trace_pkg::dbg_cfg_t   dbg_i;
	logic                  rd_i;
	trace_pkg::trace_rec_t rec_o;
	logic                  tracing_o;

	logic        read_en;            // Records may be consumed
	logic [31:0] lcg_state;
	int          errors     = 0;     // Flow failures and timeouts
	int          rec_errors = 0;     // Record mismatches
	int          n_checked  = 0;
	int          n_seen     = 0;     // Records taken from the port
	int          n_addr     = 0;
	int          n_hist     = 0;

	`include "trace_model.svh"

	trace_unit #(
		.fifo_depth_log2 (fifo_depth_log2)
	) i_dut (
		.clk_g     (clk_g),
		.rst_i     (rst_i),
		.commit_i  (commit_i),
		.dbg_i     (dbg_i),
		.rd_i      (rd_i),
		.rec_o     (rec_o),
		.tracing_o (tracing_o)
	);

	initial begin
		clk_g = 1'b0;
		forever #(clk_period / 2) clk_g = ~clk_g;
	end

	// ========================================================================
	// Helpers
	// ========================================================================
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic trace_pkg::commit_t random_commit(input logic branchy);
		trace_pkg::commit_t c;
		logic [31:0]        r;
		r        = next_rand();
		c        = '0;
		c.valid  = 1'b1;
		c.ip     = {next_rand(), next_rand()};
		c.branch = branchy && (r[3:2] != 2'b00);   // Three in four
		c.taken  = r[9];
		return c;
	endfunction

	// The model follows every commit driven here
	task automatic drive_commit(input trace_pkg::commit_t c);
		@(posedge clk_g);
		#drive_dly;
		commit_i = c;
		predict_commit(c, dbg_i);
	endtask

	task automatic step_idle();
		drive_commit('0);
	endtask

	task automatic apply_reset();
		@(posedge clk_g);
		#drive_dly;
		rst_i    = 1'b1;
		commit_i = '0;
		repeat (10) @(posedge clk_g);
		#drive_dly;
		rst_i = 1'b0;
		model_reset();
	endtask

	task automatic report_and_finish();
		$display("Done: %0d records checked, %0d record errors, %0d other errors",
			n_checked, rec_errors, errors);
		if (errors == 0 && rec_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout: %s", what);
		errors++;
	endtask

	task automatic wait_tracing(input logic level);
		int n;
		n = 0;
		while (tracing_o != level && n < wait_limit) begin
			step_idle();
			n++;
		end
		if (tracing_o != level)
			report_timeout("trace flag did not reach the expected level");
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || rec_o.valid) && n < wait_limit) begin
			step_idle();
			n++;
		end
		if (exp_q.size() != 0 || rec_o.valid)
			report_timeout("predicted records did not all come out");
	endtask

	task automatic check_count(input string what, input int got, input int want);
		assert (got == want) else begin
			$display("ERROR %s got %h expected %h", what, got, want);
			errors++;
		end
	endtask

	task automatic check_record();
		trace_pkg::trace_rec_t want;
		n_seen++;
		if (rec_o.kind == trace_pkg::kind_addr)
			n_addr++;
		else if (rec_o.kind == trace_pkg::kind_hist)
			n_hist++;
		assert (exp_q.size() != 0) else begin
			$display("A record %h came out with no record predicted", rec_o.word);
			rec_errors++;
		end
		if (exp_q.size() != 0) begin
			want = exp_q.pop_front();
			assert (rec_o.word == want.word) else begin
				$display("ERROR rec_o.word got %h expected %h", rec_o.word, want.word);
				rec_errors++;
			end
			assert (rec_o.kind == want.kind) else begin
				$display("ERROR rec_o.kind got %h expected %h", rec_o.kind, want.kind);
				rec_errors++;
			end
			assert (rec_o.count == want.count) else begin
				$display("ERROR rec_o.count got %h expected %h", rec_o.count, want.count);
				rec_errors++;
			end
			n_checked++;
		end
	endtask

	// ========================================================================
	// Comparison process
	// ========================================================================
	initial begin : compare_records
		rd_i = 1'b0;
		forever begin
			@(posedge clk_g);
			#drive_dly;
			if (read_en && rec_o.valid) begin
				check_record();
				rd_i = 1'b1;   // Consumed at the next edge
			end else begin
				rd_i = 1'b0;
			end
		end
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin : run_tests
		trace_pkg::commit_t    c;
		trace_pkg::trace_rec_t held;
		int                    n;
		int                    base;
		int                    base_addr;
		int                    base_hist;
		rst_i     = 1'b1;
		commit_i  = '0;
		dbg_i     = '0;
		read_en   = 1'b1;
		lcg_state = 32'hece8626e;
		apply_reset();

		// Commits hit the disabled slots only
		dbg_i.match_addr[0] = 64'h0000_0000_0000_1000;
		dbg_i.match_addr[1] = 64'h0000_0000_0000_2000;
		dbg_i.match_addr[3] = 64'h0000_0000_0000_3000;
		dbg_i.slot_en       = 4'b1000;
		base = n_seen;
		for (int i = 0; i < 25; i++) begin
			if (i < 20) begin
				c = random_commit(1'b1);
				if (i[0])
					c.ip = dbg_i.match_addr[1];
				else
					c.ip = dbg_i.match_addr[0];
				drive_commit(c);
			end else begin
				step_idle();
			end
			assert (tracing_o == 1'b0) else begin
				$display("ERROR tracing_o got %h expected %h", tracing_o, 1'b0);
				errors++;
			end
		end
		wait_drained();
		check_count("records while idle", n_seen - base, 0);

		// Uncompressed mode records every commit after the trigger as an address
		apply_reset();
		dbg_i               = '0;
		dbg_i.match_addr[2] = trig_addr;
		dbg_i.slot_en       = 4'b0100;
		repeat (3) drive_commit(random_commit(1'b0));
		c    = random_commit(1'b0);
		c.ip = trig_addr;
		drive_commit(c);
		wait_tracing(1'b1);
		base = n_seen;
		repeat (30) drive_commit(random_commit(1'b0));
		wait_drained();
		check_count("address records", n_seen - base, 30);

		// Compressed random branch stream
		apply_reset();
		dbg_i.compress = 1'b1;
		c    = random_commit(1'b0);
		c.ip = trig_addr;
		drive_commit(c);
		wait_tracing(1'b1);
		base_addr = n_addr;
		base_hist = n_hist;
		repeat (600) drive_commit(random_commit(1'b1));
		wait_drained();
		assert (n_hist - base_hist > trace_pkg::flushes_per_addr) else begin
			$display("Too few full history records came out of the branch stream");
			errors++;
		end
		assert (n_addr - base_addr >= 2) else begin
			$display("No forced address record followed the fourth flush");
			errors++;
		end

		// Jumps flush partial and empty history words
		apply_reset();
		c    = random_commit(1'b0);
		c.ip = trig_addr;
		drive_commit(c);
		wait_tracing(1'b1);
		base_addr = n_addr;
		base_hist = n_hist;
		drive_commit(random_commit(1'b0));   // Owed address
		for (int i = 0; i < 5; i++) begin
			c        = random_commit(1'b0);
			c.branch = 1'b1;
			c.taken  = i[0];
			drive_commit(c);
		end
		c      = random_commit(1'b0);
		c.jump = 1'b1;
		drive_commit(c);                     // Five bits
		drive_commit(random_commit(1'b0));
		drive_commit(c);                     // No bits
		drive_commit(random_commit(1'b0));
		wait_drained();
		check_count("history records after jumps", n_hist - base_hist, 2);
		check_count("address records after jumps", n_addr - base_addr, 3);

		// Back-pressure fills the buffer and stops tracing
		apply_reset();
		dbg_i.compress = 1'b0;
		read_en        = 1'b0;
		c    = random_commit(1'b0);
		c.ip = trig_addr;
		drive_commit(c);
		wait_tracing(1'b1);
		base = n_seen;
		n    = 0;
		while (tracing_o && n < wait_limit) begin
			drive_commit(random_commit(1'b0));
			n++;
		end
		if (tracing_o)
			report_timeout("tracing did not stop with a full buffer");
		step_idle();
		held = rec_o;
		repeat (30) begin
			step_idle();
			assert (rec_o.valid && rec_o == held) else begin
				$display("ERROR rec_o got %h expected %h", rec_o, held);
				errors++;
			end
		end
		read_en = 1'b1;
		wait_drained();
		repeat (10) step_idle();   // Late extras show up as unexpected
		check_count("records kept at full", n_seen - base, rec_cap);

		report_and_finish();
	end

endmodule

`default_nettype wire

// ==== hdl/trace_unit.sv ====
// Instruction trace unit
// Recorder builds trace records from retired instructions, the FIFO
// buffers them, and the readout port hands them out one at a time
`timescale 1ns/1ns
`default_nettype none

module trace_unit #(
	parameter int fifo_depth_log2 = 4   // Buffer holds 2**n records
) (
	input  wire                   clk_g,
	input  wire                   rst_i,
	input  trace_pkg::commit_t    commit_i,
	input  trace_pkg::dbg_cfg_t   dbg_i,
	input  wire                   rd_i,
	output trace_pkg::trace_rec_t rec_o,
	output logic                  tracing_o
);

	logic                   wr;
	trace_pkg::trace_word_t word;
	logic                   full;
	logic                   empty;
	logic                   pop;
	trace_pkg::trace_word_t head;

	trace_recorder i_recorder (
		.clk_g     (clk_g),
		.rst_i     (rst_i),
		.commit_i  (commit_i),
		.dbg_i     (dbg_i),
		.full_i    (full),
		.wr_o      (wr),
		.word_o    (word),
		.tracing_o (tracing_o)
	);

	trace_fifo #(
		.fifo_depth_log2 (fifo_depth_log2)
	) i_fifo (
		.clk_g   (clk_g),
		.rst_i   (rst_i),
		.wr_i    (wr),
		.din_i   (word),
		.rd_i    (pop),
		.dout_o  (head),
		.full_o  (full),
		.empty_o (empty)
	);

	trace_port i_port (
		.clk_g   (clk_g),
		.rst_i   (rst_i),
		.empty_i (empty),
		.head_i  (head),
		.pop_o   (pop),
		.rd_i    (rd_i),
		.rec_o   (rec_o)
	);

endmodule

`default_nettype wire

// ==== hdl/trace_port.sv ====
// Trace readout port
// Holds one record taken from the trace buffer, decodes its kind and
// branch count, and keeps it on the output until the reader strobes it.
// Refills in the same cycle when more records wait.
`timescale 1ns/1ns
`default_nettype none

module trace_port (
	input  wire                    clk_g,
	input  wire                    rst_i,
	input  wire                    empty_i,
	input  trace_pkg::trace_word_t head_i,
	output logic                   pop_o,
	input  wire                    rd_i,
	output trace_pkg::trace_rec_t  rec_o
);

	trace_pkg::trace_rec_t rec_q;
	logic                  take;

	// Load when the holding register is free or being read this cycle
	assign take  = !empty_i && (!rec_q.valid || rd_i);
	assign pop_o = take;

	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			rec_q.valid <= 1'b0;
		end else if (take) begin
			rec_q.valid <= 1'b1;
		end else if (rd_i) begin
			rec_q.valid <= 1'b0;
		end
	end

	// ========================================================================
	// Record decode
	// ========================================================================
	always_ff @(posedge clk_g) begin
		if (take) begin
			rec_q.word <= head_i;
			rec_q.kind <= head_i[1:0];
			if (head_i[1:0] == trace_pkg::kind_hist)
				rec_q.count <= head_i[trace_pkg::hist_base-1:2];
			else
				rec_q.count <= '0;   // Address records carry no bits
		end
	end

	assign rec_o = rec_q;

	// Shown record holds still until the reader takes it
	a_rec_stable: assert property (
		@(posedge clk_g) disable iff (rst_i)
		rec_q.valid && !rd_i |=> rec_q.valid && $stable(rec_q.word)
	);

endmodule

`default_nettype wire

// ==== hdl/trace_fifo.sv ====
// Trace buffer
// Synchronous FIFO of 64 bit trace records. The head word is shown
// whenever the buffer holds data and a read strobe pops it. Writes
// that arrive while full are dropped.
`timescale 1ns/1ns
`default_nettype none

module trace_fifo #(
	parameter int fifo_depth_log2 = 4
) (
	input  wire                    clk_g,
	input  wire                    rst_i,
	input  wire                    wr_i,
	input  trace_pkg::trace_word_t din_i,
	input  wire                    rd_i,
	output trace_pkg::trace_word_t dout_o,
	output logic                   full_o,
	output logic                   empty_o
);

	localparam int aw    = fifo_depth_log2;
	localparam int depth = 2 ** fifo_depth_log2;

	trace_pkg::trace_word_t mem_q [0:depth-1];
	logic [aw:0] wr_ptr_q;   // Extra bit tells full from empty
	logic [aw:0] rd_ptr_q;
	logic        wr_ok;
	logic        rd_ok;

	// ========================================================================
	// Status
	// ========================================================================
	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full_o  = (wr_ptr_q[aw] != rd_ptr_q[aw]) &&
	                 (wr_ptr_q[aw-1:0] == rd_ptr_q[aw-1:0]);

	assign wr_ok = wr_i && !full_o;
	assign rd_ok = rd_i && !empty_o;

	// ========================================================================
	// Pointers and storage
	// ========================================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (wr_ok)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (rd_ok)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge clk_g) begin
		if (wr_ok)
			mem_q[wr_ptr_q[aw-1:0]] <= din_i;
	end

	assign dout_o = mem_q[rd_ptr_q[aw-1:0]];   // Head word

	// The readout side never pops an empty buffer
	a_no_read_empty: assert property (
		@(posedge clk_g) disable iff (rst_i)
		rd_i |-> !empty_o
	);

endmodule

`default_nettype wire

// ==== hdl/trace_recorder.sv ====
// Trace recorder
// Watches the debug comparators to switch tracing on, stops it when the
// trace buffer fills, and turns retired instructions into address records
// or packed branch history records. One record at most per commit, written
// to the buffer one cycle after the commit.
`timescale 1ns/1ns
`default_nettype none

module trace_recorder (
	input  wire                   clk_g,
	input  wire                   rst_i,
	input  trace_pkg::commit_t    commit_i,
	input  trace_pkg::dbg_cfg_t   dbg_i,
	input  wire                   full_i,
	output logic                  wr_o,
	output trace_pkg::trace_word_t word_o,
	output logic                  tracing_o
);

	localparam int fc_w = $clog2(trace_pkg::flushes_per_addr);
	localparam logic [fc_w-1:0] flush_last = fc_w'(trace_pkg::flushes_per_addr - 1);
	localparam logic [trace_pkg::cnt_w-1:0] cnt_full = trace_pkg::cnt_w'(trace_pkg::hist_max);
	localparam logic [trace_pkg::cnt_w-1:0] cnt_last = trace_pkg::cnt_w'(trace_pkg::hist_max - 1);

	logic [trace_pkg::n_match-1:0]  slot_hit;
	logic                           trace_on;
	logic                           rec_en;
	logic                           tron_q;      // Trace flag
	logic                           pend_q;      // Address record owed
	logic [trace_pkg::cnt_w-1:0]    count_q;
	logic [fc_w-1:0]                flush_q;
	logic [trace_pkg::hist_max-1:0] hist_q;
	logic [trace_pkg::hist_max-1:0] hist_app;    // History with this commit's bit
	logic                           wr_q;
	trace_pkg::trace_word_t         word_q;

	// Packs branch bits and their count into a history record
	function automatic trace_pkg::trace_word_t hist_word(
		input logic [trace_pkg::hist_max-1:0] bits,
		input logic [trace_pkg::cnt_w-1:0]    cnt
	);
		trace_pkg::trace_word_t w;
		w = '0;
		w[trace_pkg::hist_base +: trace_pkg::hist_max] = bits;
		w[trace_pkg::hist_base-1:2] = cnt;
		w[1:0] = trace_pkg::kind_hist;
		return w;
	endfunction

	// ========================================================================
	// Debug address match
	// ========================================================================
	always_comb begin
		for (int i = 0; i < trace_pkg::n_match; i++) begin
			slot_hit[i] = dbg_i.slot_en[i] && (dbg_i.match_addr[i] == commit_i.ip);
		end
	end

	assign trace_on = commit_i.valid && |slot_hit;
	assign rec_en   = tron_q && commit_i.valid;   // Flag must already be up

	always_comb begin
		hist_app = hist_q;
		hist_app[count_q] = commit_i.taken;
	end

	// ========================================================================
	// Control state
	// ========================================================================
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			tron_q  <= 1'b0;
			pend_q  <= 1'b0;
			count_q <= '0;
			flush_q <= '0;
			hist_q  <= '0;
			wr_q    <= 1'b0;
		end else begin
			wr_q <= 1'b0;
			if (full_i) begin
				tron_q <= 1'b0;   // Buffer full stops tracing
			end else if (trace_on) begin
				tron_q <= 1'b1;
				if (!tron_q)
					pend_q <= 1'b1;
			end
			if (rec_en) begin
				if (!dbg_i.compress || pend_q) begin
					wr_q   <= 1'b1;   // Address record
					pend_q <= 1'b0;
				end else if (commit_i.branch) begin
					if (count_q == cnt_last) begin
						// Last bit goes in first, then the word flushes
						wr_q    <= 1'b1;
						count_q <= '0;
						hist_q  <= '0;
						if (flush_q == flush_last) begin
							pend_q  <= 1'b1;
							flush_q <= '0;
						end else begin
							flush_q <= flush_q + 1'b1;
						end
					end else begin
						hist_q  <= hist_app;
						count_q <= count_q + 1'b1;
					end
				end else if (commit_i.jump) begin
					wr_q    <= 1'b1;   // Partial history, count may be zero
					count_q <= '0;
					hist_q  <= '0;
					pend_q  <= 1'b1;
					flush_q <= '0;
				end
			end
		end
	end

	// Record payload, only meaningful with wr_q
	always_ff @(posedge clk_g) begin
		if (rec_en) begin
			if (!dbg_i.compress || pend_q)
				word_q <= {commit_i.ip[trace_pkg::addr_w-1:2], trace_pkg::kind_addr};
			else if (commit_i.branch)
				word_q <= hist_word(hist_app, cnt_full);
			else
				word_q <= hist_word(hist_q, count_q);
		end
	end

	assign wr_o      = wr_q;
	assign word_o    = word_q;
	assign tracing_o = tron_q;

	// History count stays within one record
	a_count_range: assert property (
		@(posedge clk_g) disable iff (rst_i)
		count_q <= cnt_full
	);

endmodule

`default_nettype wire

// ==== hdl/trace_pkg.sv ====
// Instruction trace unit shared definitions
// Record layout constants, record kinds and the structs that carry
// retired instructions, debug setup and decoded trace records
`default_nettype none

package trace_pkg;

	// ========================================================================
	// Record format
	// ========================================================================
	localparam int addr_w           = 64;  // Instruction address width
	localparam int n_match          = 4;   // Debug comparator slots
	localparam int hist_base        = 8;   // First branch bit in a history record
	localparam int hist_max         = 54;  // Branch bits that fill a record
	localparam int flushes_per_addr = 4;   // Full flushes per forced address record
	localparam int cnt_w            = 6;   // Width of the history count field

	localparam logic [1:0] kind_addr = 2'd0;
	localparam logic [1:0] kind_hist = 2'd1;

	// Raw 64 bit record as held in the trace buffer
	typedef logic [63:0] trace_word_t;

	// ========================================================================
	// Structs
	// ========================================================================

	// One retired instruction
	typedef struct packed {
		logic              valid;
		logic [addr_w-1:0] ip;
		logic              branch;   // Conditional branch
		logic              taken;    // Branch outcome
		logic              jump;     // Unconditional flow change
	} commit_t;

	// Debug comparators and trace mode
	typedef struct packed {
		logic [n_match-1:0][addr_w-1:0] match_addr;
		logic [n_match-1:0]             slot_en;
		logic                           compress;   // Branch history mode
	} dbg_cfg_t;

	// Decoded record shown at the readout port
	typedef struct packed {
		logic             valid;
		logic [1:0]       kind;
		logic [cnt_w-1:0] count;   // Branch bits held, zero for addresses
		trace_word_t      word;
	} trace_rec_t;

endpackage

`default_nettype wire
